//--- Bender.yml
package:
  name: cnn_buf

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cnnDataPkg.sv
      - verilog/cnnAddrPkg.sv
      - verilog/weightPacker.sv
      - verilog/dotEngine.sv
      - verilog/resultBuffer.sv
      - verilog/cnnBufTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/cnnBuf_asserts.sv
      - verification/cnnBufChecker.sv
      - verification/cnnBufTb.sv

//--- verification/cnnBufChecker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module cnnBufChecker (
  input  logic                  clkA,
  input  logic                  arstN,
  input  logic                  wgtWe,
  input  cnnAddrPkg::laneAddrT  wgtAddr,
  input  cnnDataPkg::weightT    wgtData,
  input  logic                  start,
  input  cnnAddrPkg::rowAddrT   rowSel,
  input  cnnDataPkg::pixelVecT  pixels,
  input  cnnAddrPkg::resAddrT   resSel,
  input  logic                  rdEn,
  input  cnnAddrPkg::resAddrT   rdAddr,
  input  cnnDataPkg::sumT       rdData,
  input  logic                  rdValid,
  output int                    errCount,
  output int                    compareCount
);

  import cnnDataPkg::*;
  import cnnAddrPkg::*;

  weightRowT wgtModel [`W_ROWS];
  sumT resModel [`RES_DEPTH];
  int unsigned cycle;

  // Engine writes waiting to land, and reads waiting for rdValid.
  int unsigned wrDueQ [$];
  resAddrT wrAddrQ [$];
  sumT wrDataQ [$];
  sumT expQ [$];
  resAddrT rdAddrQ [$];
  int unsigned rdCycleQ [$];

  // Signed dot product over all lanes.
  function automatic sumT dotRef(input weightRowT w, input pixelVecT p);
    int acc;
    acc = 0;
    for (int i = 0; i < `LANES; i++) begin
      acc += int'($signed(w[i])) * int'($signed(p[i]));
    end
    return sumT'(acc);
  endfunction

  always @(posedge clkA or negedge arstN) begin : monitor
    sumT expSum;
    resAddrT expAddr;
    int unsigned issued;
    if (!arstN) begin
      cycle = 0;
      errCount = 0;
      compareCount = 0;
      wrDueQ.delete();
      wrAddrQ.delete();
      wrDataQ.delete();
      expQ.delete();
      rdAddrQ.delete();
      rdCycleQ.delete();
    end else begin
      cycle++;
      // Results land three cycles after their start.
      while (wrDueQ.size() > 0 && wrDueQ[0] == cycle) begin
        void'(wrDueQ.pop_front());
        resModel[wrAddrQ.pop_front()] = wrDataQ.pop_front();
      end
      if (rdValid) begin
        if (expQ.size() == 0) begin
          errCount++;
          $display("rdValid went high at %0t ns with no read pending", $time);
        end else begin
          expSum = expQ.pop_front();
          expAddr = rdAddrQ.pop_front();
          issued = rdCycleQ.pop_front();
          compareCount++;
          if (rdData !== expSum) begin
            errCount++;
            $display("[FAIL] %0t ns: result %0d expected %0d, got %0d",
                     $time, expAddr, expSum, rdData);
          end
          if (cycle != issued + `RES_LATENCY) begin
            errCount++;
            $display("Read of result %0d came back %0d cycles after its rdEn",
                     expAddr, cycle - issued);
          end
        end
      end
      // Write-first, so reads see the writes applied above.
      if (rdEn) begin
        expQ.push_back(resModel[rdAddr]);
        rdAddrQ.push_back(rdAddr);
        rdCycleQ.push_back(cycle);
      end
      // Row is fetched before this edge's weight write lands.
      if (start) begin
        wrDueQ.push_back(cycle + 3);
        wrAddrQ.push_back(resSel);
        wrDataQ.push_back(dotRef(wgtModel[rowSel], pixels));
      end
      if (wgtWe) begin
        wgtModel[wgtAddr[laneBits +: rowBits]][wgtAddr[laneBits-1:0]] = wgtData;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/cnnBufTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module cnnBufTb;

  import cnnDataPkg::*;
  import cnnAddrPkg::*;

  localparam int clkPeriod = 20;
  // Reset, preload, then the five tests.
  localparam int totalCycles = 4 + 260 + 24 + 32 + 92 + 28 + 44;
  localparam int watchdogNs = totalCycles * clkPeriod * 3 / 2;

  logic clkA;
  logic arstN;
  logic wgtWe;
  laneAddrT wgtAddr;
  weightT wgtData;
  logic start;
  rowAddrT rowSel;
  pixelVecT pixels;
  resAddrT resSel;
  logic rdEn;
  resAddrT rdAddr;
  sumT rdData;
  logic rdValid;

  int errCount;
  int compareCount;
  int tbErrors;
  int testNum;
  int testsOk;
  int testsBad;
  int failsBefore;
  int baseReads;
  int unsigned lcgState;
  pixelVecT pv;

  cnnBufTop u_cnnBufTop (
    .clkA(clkA), .arstN(arstN),
    .wgtWe(wgtWe), .wgtAddr(wgtAddr), .wgtData(wgtData),
    .start(start), .rowSel(rowSel), .pixels(pixels), .resSel(resSel),
    .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData), .rdValid(rdValid)
  );

  cnnBufChecker u_checker (
    .clkA(clkA), .arstN(arstN),
    .wgtWe(wgtWe), .wgtAddr(wgtAddr), .wgtData(wgtData),
    .start(start), .rowSel(rowSel), .pixels(pixels), .resSel(resSel),
    .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData), .rdValid(rdValid),
    .errCount(errCount), .compareCount(compareCount)
  );

  bind resultBuffer cnnBufAsserts #(.LATENCY(LATENCY)) u_asserts (
    .clkA(clkA), .arstN(arstN), .rdEn(rdEn), .rdValid(rdValid), .rdData(rdData)
  );

  initial begin
    clkA = 1'b0;
    forever #(clkPeriod / 2) clkA = ~clkA;
  end

  initial begin
    #(watchdogNs);
    $display("Simulation timed out after %0d ns before the tests completed", watchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic int unsigned lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic pixelVecT randPixels();
    pixelVecT p;
    for (int i = 0; i < `LANES; i++) begin
      p[i] = pixelT'(lcgNext() >> 8);
    end
    return p;
  endfunction

  // Even lanes get a, odd lanes get b.
  function automatic pixelVecT fillPixels(input int a, input int b);
    pixelVecT p;
    for (int i = 0; i < `LANES; i++) begin
      p[i] = pixelT'((i % 2 == 0) ? a : b);
    end
    return p;
  endfunction

  function int totalFails();
    return errCount + tbErrors + u_cnnBufTop.u_resultBuffer.u_asserts.failCount;
  endfunction

  task automatic advance();
    @(posedge clkA);
    #2;
    wgtWe = 1'b0;
    start = 1'b0;
    rdEn = 1'b0;
  endtask

  task automatic writeWeight(input int row, input int lane, input int data);
    wgtWe = 1'b1;
    wgtAddr = laneAddrT'(row * `LANES + lane);
    wgtData = weightT'(data);
    advance();
  endtask

  task automatic startDot(input int row, input pixelVecT p, input int addr);
    start = 1'b1;
    rowSel = rowAddrT'(row);
    pixels = p;
    resSel = resAddrT'(addr);
    advance();
  endtask

  task automatic readResult(input int addr);
    rdEn = 1'b1;
    rdAddr = resAddrT'(addr);
    advance();
  endtask

  task automatic waitResults(input int target);
    while (compareCount < target) begin
      @(negedge clkA);
    end
    @(posedge clkA);
    #2;
  endtask

  task automatic beginTest();
    testNum++;
    failsBefore = totalFails();
    baseReads = compareCount;
  endtask

  task automatic endTest(input string name);
    int fails;
    fails = totalFails() - failsBefore;
    if (fails == 0) begin
      testsOk++;
    end else begin
      testsBad++;
    end
    $display("test %0d %s: %0s, %0d errors", testNum, name, (fails == 0) ? "ok" : "bad", fails);
  endtask

  initial begin
    lcgState = 59372;
    arstN = 1'b0;
    wgtWe = 1'b0;
    wgtAddr = '0;
    wgtData = '0;
    start = 1'b0;
    rowSel = '0;
    pixels = '0;
    resSel = '0;
    rdEn = 1'b0;
    rdAddr = '0;
    tbErrors = 0;
    testNum = 0;
    testsOk = 0;
    testsBad = 0;
    repeat (4) @(posedge clkA);
    #2;
    arstN = 1'b1;
    advance();

    // Every row gets known weights.
    for (int r = 0; r < `W_ROWS; r++) begin
      for (int l = 0; l < `LANES; l++) begin
        writeWeight(r, l, int'(lcgNext() >> 16));
      end
    end

    beginTest();
    for (int l = 0; l < `LANES; l++) begin
      writeWeight(3, l, l * 13 - 50);
    end
    pv = randPixels();
    startDot(3, pv, 0);
    writeWeight(3, 5, 77);
    startDot(3, pv, 1);
    repeat (3) advance();
    readResult(0);
    readResult(1);
    waitResults(baseReads + 2);
    endTest("lane isolation");

    beginTest();
    for (int l = 0; l < `LANES; l++) begin
      writeWeight(4, l, -128);
      writeWeight(5, l, (l % 2 == 0) ? -128 : 127);
    end
    startDot(4, fillPixels(-128, -128), 2);
    startDot(4, fillPixels(127, 127), 3);
    startDot(5, fillPixels(127, -128), 4);
    startDot(5, fillPixels(-128, -128), 5);
    repeat (3) advance();
    for (int a = 2; a < 6; a++) begin
      readResult(a);
    end
    waitResults(baseReads + 4);
    endTest("signed extremes");

    beginTest();
    for (int i = 0; i < 40; i++) begin
      startDot(int'(lcgNext() % `W_ROWS), randPixels(), 10 + i);
    end
    repeat (3) advance();
    for (int i = 0; i < 40; i++) begin
      readResult(10 + i);
    end
    waitResults(baseReads + 40);
    endTest("back-to-back starts");

    beginTest();
    startDot(1, randPixels(), 60);
    startDot(2, randPixels(), 60);
    startDot(7, randPixels(), 61);
    repeat (3) advance();
    readResult(60);
    // Read lands on the same edge as the engine write.
    startDot(6, randPixels(), 61);
    advance();
    advance();
    readResult(61);
    waitResults(baseReads + 2);
    endTest("overwrite and write-first");

    beginTest();
    for (int i = 0; i < 8; i++) begin
      advance();
      if (rdValid) begin
        tbErrors++;
        $display("rdValid pulsed at %0t ns during idle cycles with no read issued", $time);
      end
    end
    for (int i = 0; i < 4; i++) begin
      readResult(10 + i);
      waitResults(baseReads + i + 1);
    end
    for (int i = 0; i < 6; i++) begin
      readResult(20 + i);
    end
    waitResults(baseReads + 10);
    for (int i = 0; i < 4; i++) begin
      advance();
      if (rdValid) begin
        tbErrors++;
        $display("rdValid still high at %0t ns after the last expected result", $time);
      end
    end
    endTest("read latency and strobes");

    $display("%0d tests ok, %0d tests bad, %0d reads compared, %0d errors",
             testsOk, testsBad, compareCount, totalFails());
    if (totalFails() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/cnnBuf_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module cnnBufAsserts #(
  parameter int LATENCY = `RES_LATENCY
) (
  input logic             clkA,
  input logic             arstN,
  input logic             rdEn,
  input logic             rdValid,
  input cnnDataPkg::sumT  rdData
);

  int failCount = 0;

  // Every read returns its strobe exactly LATENCY cycles later.
  assert property (@(posedge clkA) disable iff (!arstN) rdEn |-> ##LATENCY rdValid)
    else begin
      failCount++;
      $error("rdValid missing %0d cycles after rdEn", LATENCY);
    end

  assert property (@(posedge clkA) disable iff (!arstN) rdValid |-> $past(rdEn, LATENCY))
    else begin
      failCount++;
      $error("rdValid without a read %0d cycles earlier", LATENCY);
    end

  assert property (@(posedge clkA) rdValid |-> !$isunknown(rdData))
    else begin
      failCount++;
      $error("rdData unknown while rdValid is high");
    end

  assert property (@(posedge clkA) !arstN |-> !rdValid)
    else begin
      failCount++;
      $error("rdValid high during reset");
    end

endmodule

`default_nettype wire

//--- verilog/cnnAddrPkg.sv
`default_nettype none

`include "cnnBuf_cfg.svh"

package cnnAddrPkg;

  localparam int laneBits = $clog2(`LANES);
  localparam int rowBits = $clog2(`W_ROWS);

  // Narrow address, row in the upper bits and lane in the lower bits.
  typedef logic [rowBits+laneBits-1:0] laneAddrT;

  typedef logic [rowBits-1:0] rowAddrT;

  typedef logic [$clog2(`RES_DEPTH)-1:0] resAddrT;

endpackage

`default_nettype wire

//--- verilog/cnnBufTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module cnnBufTop (
  input  logic                  clkA,
  input  logic                  arstN,
  input  logic                  wgtWe,
  input  cnnAddrPkg::laneAddrT  wgtAddr,
  input  cnnDataPkg::weightT    wgtData,
  input  logic                  start,
  input  cnnAddrPkg::rowAddrT   rowSel,
  input  cnnDataPkg::pixelVecT  pixels,
  input  cnnAddrPkg::resAddrT   resSel,
  input  logic                  rdEn,
  input  cnnAddrPkg::resAddrT   rdAddr,
  output cnnDataPkg::sumT       rdData,
  output logic                  rdValid
);

  import cnnDataPkg::*;
  import cnnAddrPkg::*;

  // Wide read port between packer and engine.
  logic      rowRdEn;
  rowAddrT   rowRdAddr;
  weightRowT rowWord;

  // Result write port.
  logic    resWe;
  resAddrT resWrAddr;
  sumT     resWrData;

  weightPacker u_weightPacker (
    .clkA      (clkA),
    .wgtWe     (wgtWe),
    .wgtAddr   (wgtAddr),
    .wgtData   (wgtData),
    .rowRdEn   (rowRdEn),
    .rowRdAddr (rowRdAddr),
    .rowWord   (rowWord)
  );

  dotEngine u_dotEngine (
    .clkA      (clkA),
    .arstN     (arstN),
    .start     (start),
    .rowSel    (rowSel),
    .pixels    (pixels),
    .resSel    (resSel),
    .rowRdEn   (rowRdEn),
    .rowRdAddr (rowRdAddr),
    .rowWord   (rowWord),
    .resWe     (resWe),
    .resWrAddr (resWrAddr),
    .resWrData (resWrData)
  );

  resultBuffer #(
    .LATENCY (`RES_LATENCY)
  ) u_resultBuffer (
    .clkA    (clkA),
    .arstN   (arstN),
    .wrEn    (resWe),
    .wrAddr  (resWrAddr),
    .wrData  (resWrData),
    .rdEn    (rdEn),
    .rdAddr  (rdAddr),
    .rdData  (rdData),
    .rdValid (rdValid)
  );

endmodule

`default_nettype wire

//--- verilog/cnnBuf_cfg.svh
`ifndef CNN_BUF_CFG_SVH
`define CNN_BUF_CFG_SVH

// Weights per wide row.
`define LANES 8

// Weight and pixel widths.
`define K_BITS 8
`define X_BITS 8

// Result width, wide enough for eight 16-bit products.
`define Y_BITS 20

// Number of wide weight rows.
`define W_ROWS 32

// Number of result entries.
`define RES_DEPTH 64

// Result read latency in cycles.
`define RES_LATENCY 2

`endif

//--- verilog/cnnDataPkg.sv
`default_nettype none

`include "cnnBuf_cfg.svh"

package cnnDataPkg;

  // One signed weight.
  typedef logic signed [`K_BITS-1:0] weightT;

  // One signed pixel.
  typedef logic signed [`X_BITS-1:0] pixelT;

  // Full row as read by the engine, lane 0 in the low byte.
  typedef weightT [`LANES-1:0] weightRowT;

  // Pixels that go with one start.
  typedef pixelT [`LANES-1:0] pixelVecT;

  // Accumulated dot product.
  typedef logic signed [`Y_BITS-1:0] sumT;

endpackage

`default_nettype wire

//--- verilog/dotEngine.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module dotEngine (
  input  logic                   clkA,
  input  logic                   arstN,
  input  logic                   start,
  input  cnnAddrPkg::rowAddrT    rowSel,
  input  cnnDataPkg::pixelVecT   pixels,
  input  cnnAddrPkg::resAddrT    resSel,
  output logic                   rowRdEn,
  output cnnAddrPkg::rowAddrT    rowRdAddr,
  input  cnnDataPkg::weightRowT  rowWord,
  output logic                   resWe,
  output cnnAddrPkg::resAddrT    resWrAddr,
  output cnnDataPkg::sumT        resWrData
);

  import cnnDataPkg::*;
  import cnnAddrPkg::*;

  typedef logic signed [`K_BITS+`X_BITS-1:0] prodT;

  // Stage one, pixels and address wait alongside the row fetch.
  logic     s1Valid;
  pixelVecT s1Pix;
  resAddrT  s1Addr;

  // Stage two, registered products.
  logic     s2Valid;
  prodT     prodQ [`LANES];
  resAddrT  s2Addr;

  sumT prodSum;

  // Row read goes out in the same cycle as the start.
  assign rowRdEn = start;
  assign rowRdAddr = rowSel;

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
      resWe <= 1'b0;
    end else begin
      s1Valid <= start;
      s2Valid <= s1Valid;
      resWe <= s2Valid;
    end
  end

  always_ff @(posedge clkA) begin
    if (start) begin
      s1Pix <= pixels;
      s1Addr <= resSel;
    end
  end

  // The fetched row is now aligned with the delayed pixels.
  always_ff @(posedge clkA) begin
    if (s1Valid) begin
      for (int i = 0; i < `LANES; i++) begin
        prodQ[i] <= prodT'(rowWord[i]) * prodT'(s1Pix[i]);
      end
      s2Addr <= s1Addr;
    end
  end

  // Adder tree over sign-extended products.
  always_comb begin
    prodSum = '0;
    for (int i = 0; i < `LANES; i++) begin
      prodSum = prodSum + sumT'(prodQ[i]);
    end
  end

  always_ff @(posedge clkA) begin
    if (s2Valid) begin
      resWrData <= prodSum;
      resWrAddr <= s2Addr;
    end
  end

endmodule

`default_nettype wire

//--- verilog/resultBuffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module resultBuffer #(
  parameter int LATENCY = `RES_LATENCY
) (
  input  logic                 clkA,
  input  logic                 arstN,
  input  logic                 wrEn,
  input  cnnAddrPkg::resAddrT  wrAddr,
  input  cnnDataPkg::sumT      wrData,
  input  logic                 rdEn,
  input  cnnAddrPkg::resAddrT  rdAddr,
  output cnnDataPkg::sumT      rdData,
  output logic                 rdValid
);

  import cnnDataPkg::*;

  sumT resMem [`RES_DEPTH];

  sumT readWord;

  // Stage 0 is the memory output register, the rest is delay.
  sumT dataPipe [LATENCY];
  logic [LATENCY-1:0] validPipe;

  always_ff @(posedge clkA) begin
    if (wrEn) begin
      resMem[wrAddr] <= wrData;
    end
  end

  // Write-first on an address collision.
  assign readWord = (wrEn && (wrAddr == rdAddr)) ? wrData : resMem[rdAddr];

  always_ff @(posedge clkA) begin
    if (rdEn) begin
      dataPipe[0] <= readWord;
    end
    for (int i = 1; i < LATENCY; i++) begin
      dataPipe[i] <= dataPipe[i-1];
    end
  end

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      validPipe <= '0;
    end else begin
      validPipe[0] <= rdEn;
      for (int i = 1; i < LATENCY; i++) begin
        validPipe[i] <= validPipe[i-1];
      end
    end
  end

  assign rdData = dataPipe[LATENCY-1];
  assign rdValid = validPipe[LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/weightPacker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnBuf_cfg.svh"

module weightPacker (
  input  logic                   clkA,
  input  logic                   wgtWe,
  input  cnnAddrPkg::laneAddrT   wgtAddr,
  input  cnnDataPkg::weightT     wgtData,
  input  logic                   rowRdEn,
  input  cnnAddrPkg::rowAddrT    rowRdAddr,
  output cnnDataPkg::weightRowT  rowWord
);

  import cnnDataPkg::*;
  import cnnAddrPkg::*;

  // Wide storage, one entry per row of weights.
  weightRowT rowMem [`W_ROWS];

  rowAddrT wrRow;
  logic [laneBits-1:0] wrLane;
  logic [`LANES-1:0] laneEn;

  // Split the narrow address into row and lane.
  assign wrRow = wgtAddr[laneBits +: rowBits];
  assign wrLane = wgtAddr[laneBits-1:0];

  // One-hot lane enable.
  always_comb begin
    laneEn = '0;
    laneEn[wrLane] = wgtWe;
  end

  // Only the addressed lane is touched, so the rest of the row survives.
  always_ff @(posedge clkA) begin
    for (int i = 0; i < `LANES; i++) begin
      if (laneEn[i]) begin
        rowMem[wrRow][i] <= wgtData;
      end
    end
  end

  // Wide read port, word holds until the next read.
  always_ff @(posedge clkA) begin
    if (rowRdEn) begin
      rowWord <= rowMem[rowRdAddr];
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/cnnDataPkg.sv
verilog/cnnAddrPkg.sv
verilog/weightPacker.sv
verilog/dotEngine.sv
verilog/resultBuffer.sv
verilog/cnnBufTop.sv
verification/cnnBuf_asserts.sv
verification/cnnBufChecker.sv
verification/cnnBufTb.sv
